// ==== Bender.yml ====
package:
  name: fmul_wb

sources:
  - fpu_pkg.sv
  - float_classifier.sv
  - significand_multiplier.sv
  - float_multiplier.sv
  - float_rounder.sv
  - fmul_wb_regs.sv
  - fmul_top.sv
  - target: simulation
    files:
      - tb_fmul_top.sv

// ==== flist.f ====
fpu_pkg.sv
float_classifier.sv
significand_multiplier.sv
float_multiplier.sv
float_rounder.sv
fmul_wb_regs.sv
fmul_top.sv
tb_fmul_top.sv

// ==== float_classifier.sv ====
// Operand classifier that tags a binary32 value as zero, subnormal, infinity or NaN
`timescale 1ns/100ps
`default_nettype none

module float_classifier (
    input  fpu_pkg::float_t       operand_i,
    output fpu_pkg::float_class_t class_o
);

    logic exp_all_zero;
    logic exp_all_ones;
    logic frac_zero;

    // Only the two extreme exponent codes mark a special value
    assign exp_all_zero = (operand_i.exponent == 8'h00);
    assign exp_all_ones = (operand_i.exponent == 8'hFF);
    assign frac_zero    = (operand_i.significand == 23'd0);

    always_comb begin
        // Zero exponent with a zero fraction is a signed zero, otherwise a subnormal
        class_o.is_zero      = exp_all_zero & frac_zero;
        class_o.is_subnormal = exp_all_zero & ~frac_zero;
        // All-ones exponent splits on the fraction in the same way
        class_o.is_infinity  = exp_all_ones & frac_zero;
        // Signalling and quiet NaNs are not told apart here
        class_o.is_nan       = exp_all_ones & ~frac_zero;
    end

endmodule : float_classifier

`default_nettype wire

// ==== float_multiplier.sv ====
// Pipelined binary32 multiplier producing a normalised result, round bits and exceptions
`timescale 1ns/100ps
`default_nettype none

module float_multiplier #(
    parameter int unsigned CORE_STAGES = 2
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  valid_i,
    input  fpu_pkg::float_t       multiplicand_i,
    input  fpu_pkg::float_t       multiplier_i,
    input  fpu_pkg::float_class_t class_a_i,
    input  fpu_pkg::float_class_t class_b_i,
    output fpu_pkg::float_t       result_o,
    output fpu_pkg::round_bits_t  round_bits_o,
    output logic                  invalid_o,
    output logic                  overflow_o,
    output logic                  underflow_o,
    output logic                  valid_o
);

    import fpu_pkg::*;

    // Everything that travels beside the significands through the pipe
    typedef struct packed {
        logic     sign;
        exp_ext_t exp_sum;
        logic     invalid;
        logic     zero;
        logic     infinity;
    } side_t;

    // Stage 0 register, the core stages and the product register
    localparam int unsigned SIDE_DEPTH = CORE_STAGES + 2;

    // ==================================================
    // Stage 0: sign, exponent sum, hidden bits
    // ==================================================

    side_t       side_d;
    logic [7:0]  exp_a_eff;
    logic [7:0]  exp_b_eff;
    logic [23:0] sig_a_q;
    logic [23:0] sig_b_q;

    // A subnormal operand sits at exponent 1 even though its field reads 0
    assign exp_a_eff = multiplicand_i.exponent | {7'd0, class_a_i.is_subnormal};
    assign exp_b_eff = multiplier_i.exponent | {7'd0, class_b_i.is_subnormal};

    always_comb begin
        side_d.sign     = multiplicand_i.sign ^ multiplier_i.sign;
        // The bias is taken out only after normalisation
        side_d.exp_sum  = {1'b0, exp_a_eff} + {1'b0, exp_b_eff};
        // Any NaN input, or infinity against zero, has no numeric answer
        side_d.invalid  = class_a_i.is_nan | class_b_i.is_nan
                        | (class_a_i.is_infinity & class_b_i.is_zero)
                        | (class_b_i.is_infinity & class_a_i.is_zero);
        side_d.zero     = class_a_i.is_zero | class_b_i.is_zero;
        side_d.infinity = class_a_i.is_infinity | class_b_i.is_infinity;
    end

    always_ff @(posedge clk_i) begin
        // Hidden bit is one for normal operands only
        sig_a_q <= {~(class_a_i.is_zero | class_a_i.is_subnormal), multiplicand_i.significand};
        sig_b_q <= {~(class_b_i.is_zero | class_b_i.is_subnormal), multiplier_i.significand};
    end

    // ==================================================
    // Side pipe and significand product
    // ==================================================

    side_t                 side_q [SIDE_DEPTH];
    logic [SIDE_DEPTH-1:0] valid_q;
    product_t              product;
    product_t              product_q;

    // Side data is delayed to line up with the registered product
    always_ff @(posedge clk_i) begin
        side_q[0] <= side_d;
        for (int i = 1; i < SIDE_DEPTH; i++) begin
            side_q[i] <= side_q[i-1];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[SIDE_DEPTH-2:0], valid_i};
        end
    end

    significand_multiplier #(
        .CORE_STAGES (CORE_STAGES)
    ) u_sig_mul (
        .clk_i (clk_i),
        .a_i   (sig_a_q),
        .b_i   (sig_b_q),
        .p_o   (product)
    );

    always_ff @(posedge clk_i) begin
        product_q <= product;
    end

    // ==================================================
    // Final stage: normalise and pick special results
    // ==================================================

    side_t    side_f;
    logic     norm_shift;
    logic     ordinary;
    exp_ext_t exp_adj;
    exp_ext_t exp_biased;

    assign side_f     = side_q[SIDE_DEPTH-1];
    // A product of two normals lies in [1, 4), so one right shift at most
    assign norm_shift = product_q[47];
    assign exp_adj    = side_f.exp_sum + {8'd0, norm_shift};
    assign exp_biased = exp_adj - BIAS;
    assign ordinary   = ~(side_f.invalid | side_f.infinity | side_f.zero);

    assign invalid_o   = side_f.invalid;
    // Biased exponent of 255 or more cannot be encoded as a finite value
    assign overflow_o  = ordinary & (exp_adj >= BIAS + 9'd255);
    // Results below the normal range flush to zero
    assign underflow_o = ordinary & (exp_adj < BIAS + MIN_EXP);
    assign valid_o     = valid_q[SIDE_DEPTH-1];

    always_comb begin
        round_bits_o = '0;
        if (side_f.invalid) begin
            result_o = CANONICAL_NAN;
        end else if (side_f.infinity | overflow_o) begin
            result_o = {side_f.sign, 8'hFF, 23'd0};
        end else if (side_f.zero | underflow_o) begin
            result_o = {side_f.sign, 31'd0};
        end else if (norm_shift) begin
            result_o     = {side_f.sign, exp_biased[7:0], product_q[46:24]};
            round_bits_o = {product_q[23], product_q[22], |product_q[21:0]};
        end else begin
            result_o     = {side_f.sign, exp_biased[7:0], product_q[45:23]};
            round_bits_o = {product_q[22], product_q[21], |product_q[20:0]};
        end
    end

endmodule : float_multiplier

`default_nettype wire

// ==== float_rounder.sv ====
// Round-to-nearest-even stage that also completes the exception flags
`timescale 1ns/100ps
`default_nettype none

module float_rounder (
    input  fpu_pkg::float_t      result_i,
    input  fpu_pkg::round_bits_t round_bits_i,
    input  logic                 invalid_i,
    input  logic                 overflow_i,
    input  logic                 underflow_i,
    input  logic                 valid_i,
    output fpu_pkg::float_t      result_o,
    output fpu_pkg::fp_flags_t   flags_o,
    output logic                 valid_o
);

    logic        special;
    logic        round_up;
    logic [30:0] magnitude;

    assign special = invalid_i | overflow_i | underflow_i;

    // Round up above half, or at exactly half when the LSB is odd
    assign round_up = round_bits_i.guard
                    & (round_bits_i.round | round_bits_i.sticky | result_i.significand[0]);

    // A significand carry runs straight into the exponent field
    assign magnitude = {result_i.exponent, result_i.significand} + {30'd0, round_up};

    always_comb begin
        result_o = result_i;
        flags_o  = {invalid_i, overflow_i, underflow_i, 1'b0};
        if (!special) begin
            result_o = {result_i.sign, magnitude};
            flags_o.inexact = |round_bits_i;
            // Carry into the all-ones exponent leaves a zero fraction, so this is infinity
            if (round_up && magnitude[30:23] == 8'hFF) begin
                flags_o.overflow = 1'b1;
            end
        end
    end

    // The rounder is purely combinational
    assign valid_o = valid_i;

endmodule : float_rounder

`default_nettype wire

// ==== fmul_top.sv ====
// Floating-point multiply unit on a Wishbone classic bus
`timescale 1ns/100ps
`default_nettype none

module fmul_top #(
    parameter int unsigned CORE_STAGES = 2
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              wb_cyc_i,
    input  logic              wb_stb_i,
    input  logic              wb_we_i,
    input  fpu_pkg::wb_addr_t wb_adr_i,
    input  fpu_pkg::wb_data_t wb_dat_i,
    output fpu_pkg::wb_data_t wb_dat_o,
    output logic              wb_ack_o
);

    import fpu_pkg::*;

    float_t       op_a;
    float_t       op_b;
    logic         start;
    float_class_t class_a;
    float_class_t class_b;
    float_t       mul_result;
    round_bits_t  mul_round_bits;
    logic         mul_invalid;
    logic         mul_overflow;
    logic         mul_underflow;
    logic         mul_valid;
    float_t       rnd_result;
    fp_flags_t    rnd_flags;
    logic         rnd_valid;

    fmul_wb_regs u_regs (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .wb_cyc_i       (wb_cyc_i),
        .wb_stb_i       (wb_stb_i),
        .wb_we_i        (wb_we_i),
        .wb_adr_i       (wb_adr_i),
        .wb_dat_i       (wb_dat_i),
        .wb_dat_o       (wb_dat_o),
        .wb_ack_o       (wb_ack_o),
        .op_a_o         (op_a),
        .op_b_o         (op_b),
        .start_o        (start),
        .result_i       (rnd_result),
        .flags_i        (rnd_flags),
        .result_valid_i (rnd_valid)
    );

    // Classification is combinational on the held operand registers
    float_classifier u_class_a (
        .operand_i (op_a),
        .class_o   (class_a)
    );

    float_classifier u_class_b (
        .operand_i (op_b),
        .class_o   (class_b)
    );

    float_multiplier #(
        .CORE_STAGES (CORE_STAGES)
    ) u_mul (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .valid_i        (start),
        .multiplicand_i (op_a),
        .multiplier_i   (op_b),
        .class_a_i      (class_a),
        .class_b_i      (class_b),
        .result_o       (mul_result),
        .round_bits_o   (mul_round_bits),
        .invalid_o      (mul_invalid),
        .overflow_o     (mul_overflow),
        .underflow_o    (mul_underflow),
        .valid_o        (mul_valid)
    );

    float_rounder u_round (
        .result_i     (mul_result),
        .round_bits_i (mul_round_bits),
        .invalid_i    (mul_invalid),
        .overflow_i   (mul_overflow),
        .underflow_i  (mul_underflow),
        .valid_i      (mul_valid),
        .result_o     (rnd_result),
        .flags_o      (rnd_flags),
        .valid_o      (rnd_valid)
    );

endmodule : fmul_top

`default_nettype wire

// ==== fmul_vectors.hex ====
// Columns: OPA, OPB, expected RESULT, expected flags (invalid overflow underflow inexact)
// Exact products, rounding cases, special operands, overflow and underflow
3FC00000 40000000 40400000 0
C0400000 3F000000 BFC00000 0
BFC00000 BFC00000 40100000 0
3F800001 3F800001 3F800002 1
3F800001 3FE00000 3FE00002 1
3F800001 3FC00000 3FC00002 1
3F800003 3FC00000 3FC00004 1
3F918E00 3FE12000 40000000 1
7FC00000 3F800000 7FC00000 8
FF800001 40000000 7FC00000 8
7F800000 80000000 7FC00000 8
FF800000 40400000 FF800000 0
C0400000 00000000 80000000 0
FF000000 40000000 FF800000 4
7F118E00 3FE12000 7F800000 5
80800000 3F000000 80000000 2

// ==== fmul_wb_regs.sv ====
// Wishbone classic register block for operands, control, status and the result
`timescale 1ns/100ps
`default_nettype none

module fmul_wb_regs (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               wb_cyc_i,
    input  logic               wb_stb_i,
    input  logic               wb_we_i,
    input  fpu_pkg::wb_addr_t  wb_adr_i,
    input  fpu_pkg::wb_data_t  wb_dat_i,
    output fpu_pkg::wb_data_t  wb_dat_o,
    output logic               wb_ack_o,
    output fpu_pkg::float_t    op_a_o,
    output fpu_pkg::float_t    op_b_o,
    output logic               start_o,
    input  fpu_pkg::float_t    result_i,
    input  fpu_pkg::fp_flags_t flags_i,
    input  logic               result_valid_i
);

    import fpu_pkg::*;

    logic      access;
    logic      wr_stb;
    logic      start_req;
    logic      status_rd;
    logic      busy_q;
    logic      done_q;
    float_t    result_q;
    fp_flags_t flags_q;

    // A new access is seen while ack is low, ack then follows for one cycle
    assign access = wb_cyc_i & wb_stb_i & ~wb_ack_o;
    // Writes take effect in the ack cycle, the master holds the bus until then
    assign wr_stb    = wb_ack_o & wb_cyc_i & wb_stb_i & wb_we_i;
    assign start_req = wr_stb & (wb_adr_i == REG_CTRL) & wb_dat_i[0];
    assign status_rd = access & ~wb_we_i & (wb_adr_i == REG_STATUS);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= access;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            op_a_o <= '0;
            op_b_o <= '0;
        end else if (wr_stb) begin
            if (wb_adr_i == REG_OPA) begin
                op_a_o <= float_t'(wb_dat_i);
            end
            if (wb_adr_i == REG_OPB) begin
                op_b_o <= float_t'(wb_dat_i);
            end
        end
    end

    // ==================================================
    // Operation control
    // ==================================================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            start_o  <= 1'b0;
            busy_q   <= 1'b0;
            done_q   <= 1'b0;
            result_q <= '0;
            flags_q  <= '0;
        end else begin
            // A start while an operation is in flight is dropped
            start_o <= start_req & ~busy_q;
            if (start_req && !busy_q) begin
                busy_q <= 1'b1;
            end
            if (result_valid_i) begin
                // Each result replaces the previous flags
                result_q <= result_i;
                flags_q  <= flags_i;
                busy_q   <= 1'b0;
                done_q   <= 1'b1;
            end else if (status_rd) begin
                done_q <= 1'b0;
            end
        end
    end

    // Read data is registered so that it lines up with ack
    always_ff @(posedge clk_i) begin
        if (access && !wb_we_i) begin
            case (wb_adr_i)
                REG_OPA:    wb_dat_o <= wb_data_t'(op_a_o);
                REG_OPB:    wb_dat_o <= wb_data_t'(op_b_o);
                REG_STATUS: wb_dat_o <= {26'd0, flags_q, done_q, busy_q};
                REG_RESULT: wb_dat_o <= wb_data_t'(result_q);
                // CTRL is write-only
                default:    wb_dat_o <= '0;
            endcase
        end
    end

endmodule : fmul_wb_regs

`default_nettype wire

// ==== fpu_pkg.sv ====
// Shared types and constants for the binary32 floating-point multiply unit
`default_nettype none

package fpu_pkg;

    // ==================================================
    // Operand and result formats
    // ==================================================

    // IEEE-754 binary32 layout, sign in the top bit
    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] significand;
    } float_t;

    // Bits below the result LSB that drive the rounding decision
    typedef struct packed {
        logic guard;
        logic round;
        logic sticky;
    } round_bits_t;

    // Operand class as seen by the classifier
    typedef struct packed {
        logic is_zero;
        logic is_subnormal;
        logic is_infinity;
        logic is_nan;
    } float_class_t;

    // Exception flags, invalid ends up in the top bit of the status field
    typedef struct packed {
        logic invalid;
        logic overflow;
        logic underflow;
        logic inexact;
    } fp_flags_t;

    typedef logic [8:0]  exp_ext_t;
    typedef logic [47:0] product_t;
    typedef logic [31:0] wb_data_t;
    typedef logic [2:0]  wb_addr_t;

    // ==================================================
    // Constants
    // ==================================================

    localparam exp_ext_t BIAS    = 9'd127;
    // Smallest biased exponent of a normal number
    localparam exp_ext_t MIN_EXP = 9'd1;
    localparam float_t CANONICAL_NAN = 32'h7FC00000;

    // Word addresses of the register block
    localparam wb_addr_t REG_OPA    = 3'd0;
    localparam wb_addr_t REG_OPB    = 3'd1;
    localparam wb_addr_t REG_CTRL   = 3'd2;
    localparam wb_addr_t REG_STATUS = 3'd3;
    localparam wb_addr_t REG_RESULT = 3'd4;

endpackage : fpu_pkg

`default_nettype wire

// ==== significand_multiplier.sv ====
// Unsigned 24 by 24 significand multiplier with a configurable output pipeline
`timescale 1ns/100ps
`default_nettype none

module significand_multiplier #(
    parameter int unsigned CORE_STAGES = 2
) (
    input  logic              clk_i,
    input  logic [23:0]       a_i,
    input  logic [23:0]       b_i,
    output fpu_pkg::product_t p_o
);

    import fpu_pkg::*;

    product_t product_full;

    // Full-width product, the stages behind it give synthesis room to retime
    assign product_full = a_i * b_i;

    generate
        if (CORE_STAGES == 0) begin : g_comb
            assign p_o = product_full;
        end else begin : g_pipe
            product_t pipe_q [CORE_STAGES];

            // The pipe never stalls, so every stage loads on each clock
            always_ff @(posedge clk_i) begin
                pipe_q[0] <= product_full;
                for (int i = 1; i < CORE_STAGES; i++) begin
                    pipe_q[i] <= pipe_q[i-1];
                end
            end

            assign p_o = pipe_q[CORE_STAGES-1];
        end
    endgenerate

endmodule : significand_multiplier

`default_nettype wire

// ==== tb_fmul_top.sv ====
// Self-checking testbench for the Wishbone floating-point multiply unit
`timescale 1ns/100ps
`default_nettype none

module tb_fmul_top;

    import fpu_pkg::*;

    // One test case as read from the vector file
    typedef struct packed {
        float_t    op_a;
        float_t    op_b;
        float_t    result;
        fp_flags_t flags;
    } vector_t;

    localparam int NUM_VECTORS  = 16;
    localparam int ACK_TIMEOUT  = 20;
    localparam int DONE_TIMEOUT = 50;

    logic     clk_i;
    logic     rst_n_i;
    logic     wb_cyc_i;
    logic     wb_stb_i;
    logic     wb_we_i;
    wb_addr_t wb_adr_i;
    wb_data_t wb_dat_i;
    wb_data_t wb_dat_o;
    logic     wb_ack_o;

    // Four words per case hold OPA, OPB, the expected result and the expected flags
    wb_data_t vec_mem [NUM_VECTORS*4];

    fmul_top #(
        .CORE_STAGES (2)
    ) UUT (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // ==================================================
    // Bus helpers
    // ==================================================

    task automatic bus_idle();
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
    endtask

    task automatic check_value(input string name, input wb_data_t got,
                               input wb_data_t expected);
        assert (got === expected) else begin
            $display("mismatch at time %0t: %s got %h expected %h", $time, name, got, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    // Polls ack one cycle at a time just after each rising edge
    task automatic wait_ack();
        int cycles;
        cycles = 0;
        while (!wb_ack_o && cycles < ACK_TIMEOUT) begin
            @(posedge clk_i);
            #1;
            cycles++;
        end
        if (!wb_ack_o) begin
            $display("timeout: the bus never acknowledged after %0d cycles", cycles);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
        // Ack follows the request by exactly one cycle
        assert (cycles == 1) else begin
            $display("the bus acknowledged after %0d cycles instead of one", cycles);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic bus_write(input wb_addr_t addr, input wb_data_t data);
        @(posedge clk_i);
        #1;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b1;
        wb_adr_i = addr;
        wb_dat_i = data;
        wait_ack();
        // The slave commits the write on the edge where ack is high
        @(posedge clk_i);
        #1;
        // Ack drops after one cycle even though the request is still held
        check_value("wb_ack_o", {31'd0, wb_ack_o}, 32'd0);
        bus_idle();
    endtask

    task automatic bus_read(input wb_addr_t addr, output wb_data_t data);
        @(posedge clk_i);
        #1;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b0;
        wb_adr_i = addr;
        wait_ack();
        // Read data is registered together with ack
        data = wb_dat_o;
        @(posedge clk_i);
        #1;
        check_value("wb_ack_o", {31'd0, wb_ack_o}, 32'd0);
        bus_idle();
    endtask

    // Keeps reading STATUS until the done bit shows up
    task automatic wait_done(output wb_data_t status);
        int polls;
        polls  = 0;
        status = '0;
        while (!status[1] && polls < DONE_TIMEOUT) begin
            bus_read(REG_STATUS, status);
            polls++;
        end
        if (!status[1]) begin
            $display("timeout: done never set after %0d status reads", polls);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    // ==================================================
    // One multiply through the register interface
    // ==================================================

    task automatic run_vector(input int index, input vector_t vec);
        wb_data_t status;
        wb_data_t result;
        bus_write(REG_OPA, vec.op_a);
        bus_write(REG_OPB, vec.op_b);
        bus_write(REG_CTRL, 32'h0000_0001);
        wait_done(status);
        // First status read with done set also carries the flags
        check_value($sformatf("vector %0d status.busy", index), {31'd0, status[0]}, 32'd0);
        check_value($sformatf("vector %0d status.flags", index),
                    {28'd0, status[5:2]}, {28'd0, vec.flags});
        bus_read(REG_RESULT, result);
        check_value($sformatf("vector %0d result", index), result, vec.result);
        // The first STATUS read with done set has already cleared it
        bus_read(REG_STATUS, status);
        check_value($sformatf("vector %0d status.done", index), {31'd0, status[1]}, 32'd0);
    endtask

    initial begin
        vector_t  vec;
        wb_data_t rdata;
        rst_n_i = 1'b0;
        bus_idle();
        $readmemh("fmul_vectors.hex", vec_mem);
        if ($isunknown(vec_mem[NUM_VECTORS*4-1])) begin
            $display("the vector file fmul_vectors.hex is missing or too short");
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
        repeat (2) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;

        // Register values straight out of reset
        bus_read(REG_OPA, rdata);
        check_value("OPA after reset", rdata, 32'd0);
        bus_read(REG_STATUS, rdata);
        check_value("STATUS after reset", rdata, 32'd0);
        bus_read(REG_RESULT, rdata);
        check_value("RESULT after reset", rdata, 32'd0);

        // Operand read-back and the write-only CTRL register
        bus_write(REG_OPA, 32'h1234_5678);
        bus_read(REG_OPA, rdata);
        check_value("OPA read-back", rdata, 32'h1234_5678);
        bus_read(REG_CTRL, rdata);
        check_value("CTRL read", rdata, 32'd0);

        for (int i = 0; i < NUM_VECTORS; i++) begin
            vec = vector_t'({vec_mem[4*i], vec_mem[4*i+1], vec_mem[4*i+2],
                             vec_mem[4*i+3][3:0]});
            run_vector(i, vec);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule : tb_fmul_top

`default_nettype wire
